//--- tb.f
source/serdes_pkg.sv
source/clocking_pkg.sv
source/strobe_divider.sv
source/lock_fsm.sv
source/oserdes_lane.sv
source/iserdes_lane.sv
source/ocyrus_quad.sv
tb/tb_clock.sv
tb/ocyrus_quad_asserts.sv
tb/tb_ocyrus_quad.sv

//--- Makefile
# Verilator build and run for the quad serializer testbench

VERILATOR ?= verilator
TOP ?= tb_ocyrus_quad
FILE_LIST ?= tb.f
BUILD_DIR ?= obj_dir
JOBS ?= 0
VFLAGS ?= --binary --timing --assert
PASS_TEXT ?= SIMULATION PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

# the run fails unless the pass text shows up in the simulator output
run: compile
	@output="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$output"; \
	echo "$$output" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- tb/tb_ocyrus_quad.sv
`timescale 1ns/1ns

module tb_ocyrus_quad;

	// --------------------------------------------------
	// run constants
	// --------------------------------------------------

	localparam int period_ns = 100;
	localparam int reset_cycles = 10;
	localparam logic [31:0] seed = 32'ha7b7;

	localparam int lock_cycle = clocking_pkg::lock_words * serdes_pkg::bit_depth + 1; // 33
	localparam int first_load_cycle = (clocking_pkg::lock_words + 1) * serdes_pkg::bit_depth;
	localparam int lock_limit = lock_cycle + 2 * serdes_pkg::bit_depth; // give up on lock

	localparam int budget_lock = 150; // cycles per test
	localparam int budget_serial = 150;
	localparam int budget_sampling = 100;
	localparam int budget_deserial = 150;
	localparam int budget_loopback = 200;
	localparam int budget_mid_reset = 250;
	localparam int budget_total = budget_lock + budget_serial + budget_sampling
		+ budget_deserial + budget_loopback + budget_mid_reset;
	localparam int watchdog_ns = 2 * budget_total * period_ns;

	logic fast_clock;
	logic power_on_reset;
	logic test_reset; // extra pulse for the mid-stream test
	logic reset;
	serdes_pkg::lane_words_t words_in;
	serdes_pkg::lane_bits_t d_out;
	logic data_in;
	logic data_in_drive; // serial input when not looped back
	logic loopback_on; // feeds lane 0 back into the receiver
	serdes_pkg::word_t word_out;
	logic word_valid;
	logic locked;

	int cycle; // rising edges since reset release
	int value_errors;
	int other_errors;
	logic [31:0] rng_state;

	assign reset = power_on_reset | test_reset;
	assign data_in = loopback_on ? d_out[0] : data_in_drive;

	tb_clock #(
		.period_ns    (period_ns),
		.reset_cycles (reset_cycles)
	) i_clock (
		.fast_clock (fast_clock),
		.reset      (power_on_reset)
	);

	ocyrus_quad i_dut (
		.fast_clock (fast_clock),
		.reset      (reset),
		.words_in   (words_in),
		.d_out      (d_out),
		.data_in    (data_in),
		.word_out   (word_out),
		.word_valid (word_valid),
		.locked     (locked)
	);

	always_ff @(posedge fast_clock) begin
		if (reset) begin
			cycle <= 0;
		end else begin
			cycle <= cycle + 1; // equals n during cycle n
		end
	end

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic draw_words(output serdes_pkg::lane_words_t words);
		for (int lane = 0; lane < serdes_pkg::lane_count; lane++) begin
			rng_state = xorshift32(rng_state);
			words[lane] = rng_state[serdes_pkg::bit_depth-1:0]; // low byte per lane
		end
	endtask

	// loads every word period from the first one on
	function automatic bit is_load_cycle(input int c);
		return (c >= first_load_cycle) && ((c - first_load_cycle) % serdes_pkg::bit_depth == 0);
	endfunction

	task automatic next_load_cycle();
		do begin
			@(negedge fast_clock);
		end while (!is_load_cycle(cycle)); // ends on the falling edge inside a load cycle
	endtask

	task automatic compare_bit(input string name, input logic expected, input logic actual);
		assert (actual === expected) else begin
			$display("** Error at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
			value_errors++;
		end
	endtask

	task automatic compare_word(input string name, input serdes_pkg::word_t expected,
		input serdes_pkg::word_t actual);
		assert (actual === expected) else begin
			$display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
			value_errors++;
		end
	endtask

	task automatic compare_int(input string name, input int expected, input int actual);
		assert (actual == expected) else begin
			$display("** Error at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
			value_errors++;
		end
	endtask

	task automatic quiet_outputs();
		compare_bit("word_valid", 1'b0, word_valid);
		compare_word("word_out", '0, word_out);
		for (int lane = 0; lane < serdes_pkg::lane_count; lane++) begin
			compare_bit($sformatf("d_out[%0d]", lane), 1'b0, d_out[lane]);
		end
	endtask

	// starts on the falling edge where reset drops, ends in the first locked cycle
	task automatic lock_after_reset();
		int waited;
		waited = 0;
		do begin
			@(negedge fast_clock);
			waited++;
			if (!locked) begin
				quiet_outputs();
			end
		end while (!locked && waited < lock_limit);
		if (!locked) begin
			$display("locked did not rise within %0d cycles of reset release", lock_limit);
			other_errors++;
		end else begin
			compare_int("cycle of locked rise", lock_cycle, cycle);
		end
	endtask

	// one word per lane, bit 7 first; words_in takes mid_words half way through
	task automatic serial_word_out(input serdes_pkg::lane_words_t expected,
		input serdes_pkg::lane_words_t mid_words);
		for (int b = serdes_pkg::bit_depth - 1; b >= 0; b--) begin
			@(negedge fast_clock);
			for (int lane = 0; lane < serdes_pkg::lane_count; lane++) begin
				compare_bit($sformatf("d_out[%0d]", lane), expected[lane][b], d_out[lane]);
			end
			if (b == serdes_pkg::bit_depth / 2) begin
				words_in = mid_words; // between loads
			end
		end
	endtask

	// --------------------------------------------------
	// directed tests
	// --------------------------------------------------

	task automatic reset_and_lock();
		repeat (reset_cycles) begin
			@(negedge fast_clock);
			compare_bit("locked", 1'b0, locked);
			quiet_outputs();
		end
		lock_after_reset();
	endtask

	task automatic four_lane_serialization();
		serdes_pkg::lane_words_t words;
		next_load_cycle();
		repeat (4) begin
			draw_words(words);
			words_in = words; // taken at the edge ending this cycle
			serial_word_out(words, words);
		end
	endtask

	task automatic sampling_at_load();
		serdes_pkg::lane_words_t first_words;
		serdes_pkg::lane_words_t late_words;
		next_load_cycle();
		draw_words(first_words);
		draw_words(late_words);
		words_in = first_words;
		serial_word_out(first_words, late_words); // change must not leak into this word
		serial_word_out(late_words, late_words);
	endtask

	task automatic deserialization();
		serdes_pkg::word_t pattern [5];
		pattern = '{8'ha5, 8'h3c, 8'hff, 8'h00, 8'h81};
		next_load_cycle();
		for (int i = 0; i <= 5; i++) begin
			for (int k = 0; k < serdes_pkg::bit_depth; k++) begin
				@(negedge fast_clock);
				if (k == 0 && i > 0) begin
					compare_word("word_out", pattern[i-1], word_out);
					compare_bit("word_valid", 1'b1, word_valid);
				end else if (k > 0) begin
					compare_bit("word_valid", 1'b0, word_valid); // one cycle only
				end
				if (i < 5) begin
					data_in_drive = pattern[i][serdes_pkg::bit_depth-1-k]; // msb first
				end
			end
		end
	endtask

	task automatic loopback();
		serdes_pkg::lane_words_t words;
		serdes_pkg::word_t sent;
		next_load_cycle();
		loopback_on = 1'b1;
		for (int i = 0; i <= 4; i++) begin
			if (i < 4) begin
				draw_words(words);
				words_in = words;
			end
			@(negedge fast_clock);
			if (i > 0) begin
				compare_word("word_out", sent, word_out); // lane 0 word from one load back
				compare_bit("word_valid", 1'b1, word_valid);
			end
			sent = words[0];
			repeat (serdes_pkg::bit_depth - 1) @(negedge fast_clock);
		end
		loopback_on = 1'b0;
	endtask

	task automatic reset_mid_stream();
		serdes_pkg::lane_words_t words;
		next_load_cycle();
		draw_words(words);
		words_in = words;
		repeat (serdes_pkg::bit_depth / 2) @(negedge fast_clock);
		test_reset = 1'b1; // lanes are half way through a word
		repeat (4) begin
			@(negedge fast_clock);
			compare_bit("locked", 1'b0, locked);
			quiet_outputs();
		end
		test_reset = 1'b0;
		lock_after_reset();
		next_load_cycle();
		draw_words(words);
		words_in = words;
		serial_word_out(words, words); // traffic resumes after relock
	endtask

	// --------------------------------------------------
	// run control
	// --------------------------------------------------

	task automatic finish_run();
		int assert_errors;
		assert_errors = i_dut.i_asserts.fail_count; // bound property failures
		$display("errors: %0d wrong values, %0d other failures, %0d assertion failures",
			value_errors, other_errors, assert_errors);
		if (value_errors == 0 && other_errors == 0 && assert_errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	endtask

	initial begin
		#(watchdog_ns);
		$display("watchdog expired after %0d cycles, the tests did not finish", 2 * budget_total);
		other_errors++;
		finish_run();
	end

	initial begin
		test_reset = 1'b0;
		words_in = '0;
		data_in_drive = 1'b0;
		loopback_on = 1'b0;
		value_errors = 0;
		other_errors = 0;
		rng_state = seed;
		reset_and_lock();
		four_lane_serialization();
		sampling_at_load();
		deserialization();
		loopback();
		reset_mid_stream();
		finish_run();
	end

endmodule

//--- tb/ocyrus_quad_asserts.sv
`timescale 1ns/1ns

module ocyrus_quad_asserts (
	input logic fast_clock,
	input logic reset,
	input logic word_load,
	input logic locked,
	input logic word_valid,
	input serdes_pkg::lane_bits_t d_out
);

	int since_load; // cycles since the last load, saturates at bit_depth
	int fail_count = 0; // failed properties, read by the testbench summary

	always_ff @(posedge fast_clock) begin
		if (reset) begin
			since_load <= serdes_pkg::bit_depth; // a load is allowed right away
		end else if (word_load) begin
			since_load <= 1;
		end else if (since_load < serdes_pkg::bit_depth) begin
			since_load <= since_load + 1;
		end
	end

	// --------------------------------------------------
	// properties on the top level
	// --------------------------------------------------

	valid_after_load: assert property (@(posedge fast_clock) disable iff (reset)
		word_valid |-> $past(word_load))
		else begin
			$error("word_valid high without a load in the cycle before");
			fail_count++;
		end

	quiet_until_lock: assert property (@(posedge fast_clock) disable iff (reset)
		!locked |-> (d_out == '0))
		else begin
			$error("serial outputs active while not locked");
			fail_count++;
		end

	// lock is a level, only reset takes it away
	lock_held: assert property (@(posedge fast_clock)
		$fell(locked) |-> $past(reset))
		else begin
			$error("locked fell without reset");
			fail_count++;
		end

	load_spacing: assert property (@(posedge fast_clock) disable iff (reset)
		word_load |-> (since_load >= serdes_pkg::bit_depth))
		else begin
			$error("two loads closer than one word apart");
			fail_count++;
		end

endmodule

bind ocyrus_quad ocyrus_quad_asserts i_asserts (
	.fast_clock (fast_clock),
	.reset      (reset),
	.word_load  (word_load),
	.locked     (locked),
	.word_valid (word_valid),
	.d_out      (d_out)
);

//--- tb/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
	parameter int period_ns = 100,
	parameter int reset_cycles = 10
) (
	output logic fast_clock,
	output logic reset
);

	initial begin
		fast_clock = 1'b0; // first rising edge at half a period
		forever #(period_ns / 2) fast_clock = ~fast_clock;
	end

	initial begin
		reset = 1'b1;
		repeat (reset_cycles) @(negedge fast_clock); // covers reset_cycles rising edges
		reset = 1'b0; // released on a falling edge
	end

endmodule

//--- source/ocyrus_quad.sv
`timescale 1ns/1ns

module ocyrus_quad (
	input  logic fast_clock,
	input  logic reset,
	input  serdes_pkg::lane_words_t words_in,
	output serdes_pkg::lane_bits_t d_out,
	input  logic data_in,
	output serdes_pkg::word_t word_out,
	output logic word_valid,
	output logic locked
);

	logic word_strobe; // divided strobe, one cycle per word
	logic word_load; // strobe gated by lock, shared by every lane

	// --------------------------------------------------
	// clocking
	// --------------------------------------------------

	strobe_divider i_strobe_divider (
		.fast_clock  (fast_clock),
		.reset       (reset),
		.word_strobe (word_strobe)
	);

	// takes the place of the pll and bufpll lock chain
	lock_fsm i_lock_fsm (
		.fast_clock  (fast_clock),
		.reset       (reset),
		.word_strobe (word_strobe),
		.locked      (locked),
		.word_load   (word_load)
	);

	// --------------------------------------------------
	// transmit lanes
	// --------------------------------------------------

	for (genvar lane = 0; lane < serdes_pkg::lane_count; lane++) begin : g_tx
		oserdes_lane i_oserdes_lane (
			.fast_clock (fast_clock),
			.reset      (reset),
			.word_load  (word_load),
			.word_in    (words_in[lane]), // lane n sends element n
			.d_out      (d_out[lane])
		);
	end

	// --------------------------------------------------
	// receive lane
	// --------------------------------------------------

	iserdes_lane i_iserdes_lane (
		.fast_clock (fast_clock),
		.reset      (reset),
		.word_load  (word_load), // same word boundary as the transmit side
		.data_in    (data_in),
		.word_out   (word_out),
		.word_valid (word_valid)
	);

endmodule

//--- source/iserdes_lane.sv
`timescale 1ns/1ns

module iserdes_lane (
	input  logic fast_clock,
	input  logic reset,
	input  logic word_load,
	input  logic data_in,
	output serdes_pkg::word_t word_out,
	output logic word_valid
);

	serdes_pkg::word_t shift_reg; // last bit_depth samples, oldest on top
	serdes_pkg::word_t word_next; // assembled word including this edge's sample

	// --------------------------------------------------
	// serial shift in
	// --------------------------------------------------

	assign word_next = {shift_reg[serdes_pkg::bit_depth-2:0], data_in};

	always_ff @(posedge fast_clock) begin
		shift_reg <= word_next; // samples every edge, reset or not
	end

	// --------------------------------------------------
	// word capture
	// --------------------------------------------------

	always_ff @(posedge fast_clock) begin
		if (reset) begin
			word_out <= '0;
			word_valid <= 1'b0;
		end else begin
			if (word_load) begin
				word_out <= word_next; // first sample received lands in the msb
			end
			word_valid <= word_load; // single cycle after each load
		end
	end

endmodule

//--- source/oserdes_lane.sv
`timescale 1ns/1ns

module oserdes_lane (
	input  logic fast_clock,
	input  logic reset,
	input  logic word_load,
	input  serdes_pkg::word_t word_in,
	output logic d_out
);

	serdes_pkg::word_t shift_reg; // word being sent, current bit on top

	// --------------------------------------------------
	// parallel load and shift out
	// --------------------------------------------------

	// one 8-bit register does the job of the master/slave pair
	always_ff @(posedge fast_clock) begin
		if (reset) begin
			shift_reg <= '0; // line idles low until the first load
		end else if (word_load) begin
			shift_reg <= word_in; // sampled only at the load edge
		end else begin
			shift_reg <= {shift_reg[serdes_pkg::bit_depth-2:0], 1'b0}; // zero fill
		end
	end

	// msb of the word leaves first
	assign d_out = shift_reg[serdes_pkg::bit_depth-1];

endmodule

//--- source/lock_fsm.sv
`timescale 1ns/1ns

module lock_fsm (
	input  logic fast_clock,
	input  logic reset,
	input  logic word_strobe,
	output logic locked,
	output logic word_load
);

	clocking_pkg::lock_state_t state; // current sequencer state
	clocking_pkg::lock_state_t state_next;
	clocking_pkg::lock_count_t strobe_count; // strobes seen while acquiring
	logic last_strobe; // this strobe completes the lock wait

	// --------------------------------------------------
	// next state
	// --------------------------------------------------

	assign last_strobe = word_strobe
		&& (strobe_count == clocking_pkg::lock_count_t'(clocking_pkg::lock_words - 1));

	always_comb begin
		state_next = state; // hold by default
		case (state)
			clocking_pkg::state_hold: begin
				state_next = clocking_pkg::state_acquire; // leave as soon as reset drops
			end
			clocking_pkg::state_acquire: begin
				if (last_strobe) begin
					state_next = clocking_pkg::state_locked;
				end
			end
			clocking_pkg::state_locked: begin
				state_next = clocking_pkg::state_locked; // stays until reset
			end
			default: begin
				state_next = clocking_pkg::state_hold; // unused encoding
			end
		endcase
	end

	// --------------------------------------------------
	// state and strobe counter
	// --------------------------------------------------

	always_ff @(posedge fast_clock) begin
		if (reset) begin
			state <= clocking_pkg::state_hold;
			strobe_count <= '0;
		end else begin
			state <= state_next;
			if (state == clocking_pkg::state_acquire && word_strobe) begin
				strobe_count <= strobe_count + 1'b1; // only counts while acquiring
			end
		end
	end

	// --------------------------------------------------
	// outputs
	// --------------------------------------------------

	assign locked = (state == clocking_pkg::state_locked); // level, like pll lock

	// nothing is loaded before lock, after that every strobe loads a word
	assign word_load = word_strobe && (state == clocking_pkg::state_locked);

endmodule

//--- source/strobe_divider.sv
`timescale 1ns/1ns

module strobe_divider (
	input  logic fast_clock,
	input  logic reset,
	output logic word_strobe
);

	clocking_pkg::phase_t phase; // bit position within the current word
	logic phase_wrap; // last bit of the word

	// --------------------------------------------------
	// phase counter
	// --------------------------------------------------

	assign phase_wrap = (phase == clocking_pkg::phase_t'(serdes_pkg::bit_depth - 1));

	always_ff @(posedge fast_clock) begin
		if (reset) begin
			phase <= '0; // word boundary restarts here
		end else if (phase_wrap) begin
			phase <= '0; // wrap after bit_depth cycles
		end else begin
			phase <= phase + 1'b1;
		end
	end

	// --------------------------------------------------
	// registered strobe
	// --------------------------------------------------

	// one cycle high per word, same job as the io strobe from the clock buffer
	always_ff @(posedge fast_clock) begin
		if (reset) begin
			word_strobe <= 1'b0;
		end else begin
			word_strobe <= phase_wrap; // lands in the cycle the counter wraps to 0
		end
	end

endmodule

//--- source/clocking_pkg.sv
package clocking_pkg;

	// --------------------------------------------------
	// strobe generation
	// --------------------------------------------------

	// bit position inside a word, 0 .. bit_depth-1
	typedef logic [$clog2(serdes_pkg::bit_depth)-1:0] phase_t;

	// --------------------------------------------------
	// lock sequencing
	// --------------------------------------------------

	localparam int lock_words = 4; // strobes to wait after reset before lock

	typedef logic [2:0] lock_count_t; // holds 0 .. lock_words-1

	// stand-in for pll lock plus strobe alignment
	typedef enum logic [1:0] {
		state_hold    = 2'd0, // in reset
		state_acquire = 2'd1, // counting strobes
		state_locked  = 2'd2  // loads are passed through
	} lock_state_t;

endpackage

//--- source/serdes_pkg.sv
package serdes_pkg;

	// --------------------------------------------------
	// word geometry
	// --------------------------------------------------

	localparam int bit_depth = 8; // bits per word, also bit-clock cycles per word
	localparam int lane_count = 4; // transmit lanes in the quad

	// --------------------------------------------------
	// data path types
	// --------------------------------------------------

	// one parallel word, msb leaves the serializer first
	typedef logic [bit_depth-1:0] word_t;

	// one word per transmit lane, element n feeds lane n
	typedef word_t [lane_count-1:0] lane_words_t;

	// one serial bit per transmit lane
	typedef logic [lane_count-1:0] lane_bits_t;

endpackage
